//--- rtl/vector_cache_macros.svh
`ifndef VECTOR_CACHE_MACROS_SVH
`define VECTOR_CACHE_MACROS_SVH

// Request ports feeding the front end
`define VC_REQ_NUM    8

// MSHR entries, one per outstanding command
`define VC_ENTRY_NUM  16

`define VC_ADDR_W     32
`define VC_TXNID_W    8
`define VC_OPCODE_W   4
`define VC_DB_ID_W    5  // Data-buffer entry index

`endif

//--- rtl/vector_cache_pkg.sv
`default_nettype none

`include "vector_cache_macros.svh"

package vector_cache_pkg;

    // Fields of a request command
    typedef logic [`VC_ADDR_W-1:0]   cmd_addr_t;
    typedef logic [`VC_TXNID_W-1:0]  cmd_txnid_t;
    typedef logic [`VC_OPCODE_W-1:0] cmd_opcode_t;

    typedef logic [`VC_DB_ID_W-1:0]  db_entry_id_t;  // Points into the data buffer

    // The MSHR entry doubles as the reorder id of the command
    typedef logic [$clog2(`VC_ENTRY_NUM)-1:0] rob_entry_id_t;

endpackage

`default_nettype wire

//--- rtl/n_to_2_arb.sv
`timescale 1ns/1ps
`default_nettype none

module n_to_2_arb #(
    parameter int unsigned N         = 8,
    parameter int unsigned PLD_WIDTH = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [N-1:0]                 req_vld,
    input  logic [N*PLD_WIDTH-1:0]       req_pld,
    input  logic [1:0]                   slot_en,
    output logic [1:0]                   grant_vld,
    output logic [2*$clog2(N)-1:0]       grant_idx,
    output logic [2*PLD_WIDTH-1:0]       grant_pld,
    input  logic [1:0]                   grant_fire
);

    localparam int unsigned IDX_W = $clog2(N);

    logic [IDX_W-1:0] ptr;           // Requester with top priority this cycle
    logic [IDX_W-1:0] first_idx;
    logic [IDX_W-1:0] second_idx;
    logic             first_found;
    logic             second_found;
    logic [IDX_W-1:0] slot_idx_0;
    logic [IDX_W-1:0] slot_idx_1;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        logic [IDX_W-1:0] nxt;
        if (idx == IDX_W'(N - 1)) begin
            nxt = '0;
        end else begin
            nxt = idx + 1'b1;
        end
        return nxt;
    endfunction

    // Walk the requesters in circular order starting at the pointer
    always_comb begin
        int j;
        first_found  = 1'b0;
        second_found = 1'b0;
        first_idx    = '0;
        second_idx   = '0;
        for (int k = 0; k < N; k++) begin
            j = int'(ptr) + k;
            if (j >= N) begin
                j = j - N;
            end
            if (req_vld[j]) begin
                if (!first_found) begin
                    first_found = 1'b1;
                    first_idx   = IDX_W'(j);
                end else if (!second_found) begin
                    second_found = 1'b1;
                    second_idx   = IDX_W'(j);
                end
            end
        end
    end

    // Without slot 0 the first winner moves to slot 1 so it is not starved
    assign slot_idx_0   = first_idx;
    assign slot_idx_1   = slot_en[0] ? second_idx : first_idx;
    assign grant_vld[0] = slot_en[0] && first_found;
    assign grant_vld[1] = slot_en[1] && (slot_en[0] ? second_found : first_found);

    assign grant_idx = {slot_idx_1, slot_idx_0};

    assign grant_pld[0 +: PLD_WIDTH]         = req_pld[slot_idx_0*PLD_WIDTH +: PLD_WIDTH];
    assign grant_pld[PLD_WIDTH +: PLD_WIDTH] = req_pld[slot_idx_1*PLD_WIDTH +: PLD_WIDTH];

    // Slot 0 always holds the higher priority winner when it fires
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (grant_fire[0]) begin
            ptr <= next_idx(slot_idx_0);
        end else if (grant_fire[1]) begin
            ptr <= next_idx(slot_idx_1);
        end
    end

    a_distinct_winners: assert property (
        @(posedge clk) disable iff (!rst_n)
        (grant_vld[0] && grant_vld[1]) |-> (slot_idx_0 != slot_idx_1)
    );

    // Downstream may only accept what was actually offered
    a_fire_needs_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((grant_fire & ~grant_vld) == 2'b00)
    );

endmodule

`default_nettype wire

//--- rtl/mshr_free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_macros.svh"

module mshr_free_list #(
    parameter int unsigned ENTRY_NUM = `VC_ENTRY_NUM
) (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic                           alloc_vld_0,
    output vector_cache_pkg::rob_entry_id_t alloc_idx_0,
    output logic                           alloc_vld_1,
    output vector_cache_pkg::rob_entry_id_t alloc_idx_1,
    input  logic                           alloc_rdy_0,
    input  logic                           alloc_rdy_1,
    input  logic                           release_vld,
    input  vector_cache_pkg::rob_entry_id_t release_idx
);

    import vector_cache_pkg::*;

    logic [ENTRY_NUM-1:0] free_q;       // One bit per entry, set when free
    logic [ENTRY_NUM-1:0] free_rest;
    logic [ENTRY_NUM-1:0] pop_mask;
    logic [ENTRY_NUM-1:0] rel_mask;

    function automatic rob_entry_id_t lowest_set(input logic [ENTRY_NUM-1:0] vec);
        rob_entry_id_t idx;
        idx = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = rob_entry_id_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [ENTRY_NUM-1:0] onehot(input rob_entry_id_t idx);
        return ENTRY_NUM'(1) << idx;
    endfunction

    // Second search runs on the free set with the first hit removed
    assign alloc_vld_0 = |free_q;
    assign alloc_idx_0 = lowest_set(free_q);
    assign free_rest   = free_q & ~onehot(alloc_idx_0);
    assign alloc_vld_1 = |free_rest;
    assign alloc_idx_1 = lowest_set(free_rest);

    always_comb begin
        pop_mask = '0;
        if (alloc_rdy_0) begin
            pop_mask = pop_mask | onehot(alloc_idx_0);
        end
        if (alloc_rdy_1) begin
            pop_mask = pop_mask | onehot(alloc_idx_1);
        end
    end

    assign rel_mask = release_vld ? onehot(release_idx) : '0;

    // A released entry is always allocated, so it never overlaps a pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_q <= '1;
        end else begin
            free_q <= (free_q & ~pop_mask) | rel_mask;
        end
    end

    a_release_allocated: assert property (
        @(posedge clk) disable iff (!rst_n)
        release_vld |-> !free_q[release_idx]
    );

    a_pop_offered_0: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_rdy_0 |-> alloc_vld_0
    );

    a_pop_offered_1: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_rdy_1 |-> alloc_vld_1
    );

endmodule

`default_nettype wire

//--- rtl/vec_cache_8to2_req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_macros.svh"

module vec_cache_8to2_req_arbiter (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [`VC_REQ_NUM-1:0]                          req_vld,
    input  vector_cache_pkg::cmd_addr_t    [`VC_REQ_NUM-1:0] req_addr,
    input  vector_cache_pkg::cmd_txnid_t   [`VC_REQ_NUM-1:0] req_txnid,
    input  vector_cache_pkg::cmd_opcode_t  [`VC_REQ_NUM-1:0] req_opcode,
    input  vector_cache_pkg::db_entry_id_t [`VC_REQ_NUM-1:0] req_db_id,
    output logic [`VC_REQ_NUM-1:0]                          req_rdy,
    input  logic                                            alloc_vld_0,
    input  vector_cache_pkg::rob_entry_id_t                 alloc_idx_0,
    input  logic                                            alloc_vld_1,
    input  vector_cache_pkg::rob_entry_id_t                 alloc_idx_1,
    output logic                                            alloc_rdy_0,
    output logic                                            alloc_rdy_1,
    output logic                                            out_grant_vld_0,
    output vector_cache_pkg::cmd_addr_t                     out_addr_0,
    output vector_cache_pkg::cmd_txnid_t                    out_txnid_0,
    output vector_cache_pkg::cmd_opcode_t                   out_opcode_0,
    output vector_cache_pkg::db_entry_id_t                  out_db_id_0,
    output vector_cache_pkg::rob_entry_id_t                 rob_entry_id_0,
    output logic                                            out_grant_vld_1,
    output vector_cache_pkg::cmd_addr_t                     out_addr_1,
    output vector_cache_pkg::cmd_txnid_t                    out_txnid_1,
    output vector_cache_pkg::cmd_opcode_t                   out_opcode_1,
    output vector_cache_pkg::db_entry_id_t                  out_db_id_1,
    output vector_cache_pkg::rob_entry_id_t                 rob_entry_id_1,
    input  logic                                            out_grant_rdy
);

    import vector_cache_pkg::*;

    localparam int unsigned REQ_NUM = `VC_REQ_NUM;
    localparam int unsigned IDX_W   = $clog2(REQ_NUM);
    localparam int unsigned PLD_W   = $bits(cmd_addr_t) + $bits(cmd_txnid_t)
                                    + $bits(cmd_opcode_t) + $bits(db_entry_id_t);

    logic [REQ_NUM*PLD_W-1:0] req_pld;
    logic [1:0]               grant_vld;
    logic [2*IDX_W-1:0]       grant_idx;
    logic [2*PLD_W-1:0]       grant_pld;
    logic [1:0]               grant_fire;
    logic [IDX_W-1:0]         grant_idx_0;
    logic [IDX_W-1:0]         grant_idx_1;

    for (genvar i = 0; i < REQ_NUM; i++) begin : g_pack
        assign req_pld[i*PLD_W +: PLD_W] = {req_addr[i], req_txnid[i], req_opcode[i],
                                            req_db_id[i]};
    end

    n_to_2_arb #(
        .N         (REQ_NUM),
        .PLD_WIDTH (PLD_W)
    ) u_8to2_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_vld    (req_vld),
        .req_pld    (req_pld),
        .slot_en    ({alloc_vld_1, alloc_vld_0}),
        .grant_vld  (grant_vld),
        .grant_idx  (grant_idx),
        .grant_pld  (grant_pld),
        .grant_fire (grant_fire)
    );

    // A slot is offered only when it also has an MSHR entry behind it
    assign out_grant_vld_0 = grant_vld[0] && alloc_vld_0;
    assign out_grant_vld_1 = grant_vld[1] && alloc_vld_1;

    assign {out_addr_0, out_txnid_0, out_opcode_0, out_db_id_0} = grant_pld[0 +: PLD_W];
    assign {out_addr_1, out_txnid_1, out_opcode_1, out_db_id_1} = grant_pld[PLD_W +: PLD_W];
    assign rob_entry_id_0 = alloc_idx_0;
    assign rob_entry_id_1 = alloc_idx_1;

    assign grant_fire[0] = out_grant_vld_0 && out_grant_rdy;
    assign grant_fire[1] = out_grant_vld_1 && out_grant_rdy;
    assign alloc_rdy_0   = grant_fire[0];  // Entry is popped with the command
    assign alloc_rdy_1   = grant_fire[1];

    assign grant_idx_0 = grant_idx[0 +: IDX_W];
    assign grant_idx_1 = grant_idx[IDX_W +: IDX_W];

    for (genvar i = 0; i < REQ_NUM; i++) begin : g_rdy
        assign req_rdy[i] = (grant_fire[0] && (grant_idx_0 == IDX_W'(i)))
                         || (grant_fire[1] && (grant_idx_1 == IDX_W'(i)));
    end

    // Free list and arbiter together must never hand one entry to both slots
    a_distinct_rob_ids: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_grant_vld_0 && out_grant_vld_1) |-> (rob_entry_id_0 != rob_entry_id_1)
    );

endmodule

`default_nettype wire

//--- rtl/vec_cache_req_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_macros.svh"

module vec_cache_req_frontend (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [`VC_REQ_NUM-1:0]                          req_vld,
    input  vector_cache_pkg::cmd_addr_t    [`VC_REQ_NUM-1:0] req_addr,
    input  vector_cache_pkg::cmd_txnid_t   [`VC_REQ_NUM-1:0] req_txnid,
    input  vector_cache_pkg::cmd_opcode_t  [`VC_REQ_NUM-1:0] req_opcode,
    input  vector_cache_pkg::db_entry_id_t [`VC_REQ_NUM-1:0] req_db_id,
    output logic [`VC_REQ_NUM-1:0]                          req_rdy,
    output logic                                            out_grant_vld_0,
    output vector_cache_pkg::cmd_addr_t                     out_addr_0,
    output vector_cache_pkg::cmd_txnid_t                    out_txnid_0,
    output vector_cache_pkg::cmd_opcode_t                   out_opcode_0,
    output vector_cache_pkg::db_entry_id_t                  out_db_id_0,
    output vector_cache_pkg::rob_entry_id_t                 rob_entry_id_0,
    output logic                                            out_grant_vld_1,
    output vector_cache_pkg::cmd_addr_t                     out_addr_1,
    output vector_cache_pkg::cmd_txnid_t                    out_txnid_1,
    output vector_cache_pkg::cmd_opcode_t                   out_opcode_1,
    output vector_cache_pkg::db_entry_id_t                  out_db_id_1,
    output vector_cache_pkg::rob_entry_id_t                 rob_entry_id_1,
    input  logic                                            out_grant_rdy,
    input  logic                                            release_vld,
    input  vector_cache_pkg::rob_entry_id_t                 release_idx
);

    import vector_cache_pkg::*;

    logic          alloc_vld_0;
    logic          alloc_vld_1;
    rob_entry_id_t alloc_idx_0;
    rob_entry_id_t alloc_idx_1;
    logic          alloc_rdy_0;
    logic          alloc_rdy_1;

    vec_cache_8to2_req_arbiter u_req_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_vld         (req_vld),
        .req_addr        (req_addr),
        .req_txnid       (req_txnid),
        .req_opcode      (req_opcode),
        .req_db_id       (req_db_id),
        .req_rdy         (req_rdy),
        .alloc_vld_0     (alloc_vld_0),
        .alloc_idx_0     (alloc_idx_0),
        .alloc_vld_1     (alloc_vld_1),
        .alloc_idx_1     (alloc_idx_1),
        .alloc_rdy_0     (alloc_rdy_0),
        .alloc_rdy_1     (alloc_rdy_1),
        .out_grant_vld_0 (out_grant_vld_0),
        .out_addr_0      (out_addr_0),
        .out_txnid_0     (out_txnid_0),
        .out_opcode_0    (out_opcode_0),
        .out_db_id_0     (out_db_id_0),
        .rob_entry_id_0  (rob_entry_id_0),
        .out_grant_vld_1 (out_grant_vld_1),
        .out_addr_1      (out_addr_1),
        .out_txnid_1     (out_txnid_1),
        .out_opcode_1    (out_opcode_1),
        .out_db_id_1     (out_db_id_1),
        .rob_entry_id_1  (rob_entry_id_1),
        .out_grant_rdy   (out_grant_rdy)
    );

    // Entries retire back here when downstream finishes a transaction
    mshr_free_list #(
        .ENTRY_NUM (`VC_ENTRY_NUM)
    ) u_free_list (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_vld_0 (alloc_vld_0),
        .alloc_idx_0 (alloc_idx_0),
        .alloc_vld_1 (alloc_vld_1),
        .alloc_idx_1 (alloc_idx_1),
        .alloc_rdy_0 (alloc_rdy_0),
        .alloc_rdy_1 (alloc_rdy_1),
        .release_vld (release_vld),
        .release_idx (release_idx)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tb_vec_cache_req_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cache_macros.svh"

module tb_vec_cache_req_frontend;

    import vector_cache_pkg::*;

    localparam int REQ_NUM         = `VC_REQ_NUM;
    localparam int ENTRY_NUM       = `VC_ENTRY_NUM;
    localparam int IDX_W           = $clog2(REQ_NUM);
    localparam int ROB_W           = $bits(rob_entry_id_t);
    localparam int PRED_W          = 2 + 2 * IDX_W + 2 * ROB_W;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int RANDOM_CYCLES   = 1000;
    localparam int STALL_CYCLES    = 24;
    localparam int EMPTY_CYCLES    = 8;
    localparam int LOOP_BUDGET     = 428;  // Fill and drain loops have no fixed length
    localparam int TEST_CYCLES     = RESET_CYCLES + RANDOM_CYCLES + STALL_CYCLES
                                   + EMPTY_CYCLES + 2 * ENTRY_NUM + LOOP_BUDGET;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
    localparam int RDY_RANDOM      = 0;
    localparam int RDY_HIGH        = 1;
    localparam int RDY_LOW         = 2;
    localparam int REL_NONE        = 0;
    localparam int REL_RANDOM      = 1;
    localparam int REL_ONE         = 2;

    logic                          clk;
    logic                          rst_n;
    logic [REQ_NUM-1:0]            req_vld;
    cmd_addr_t    [REQ_NUM-1:0]    req_addr;
    cmd_txnid_t   [REQ_NUM-1:0]    req_txnid;
    cmd_opcode_t  [REQ_NUM-1:0]    req_opcode;
    db_entry_id_t [REQ_NUM-1:0]    req_db_id;
    logic [REQ_NUM-1:0]            req_rdy;
    logic                          out_grant_vld_0;
    logic                          out_grant_vld_1;
    cmd_addr_t                     out_addr_0;
    cmd_addr_t                     out_addr_1;
    cmd_txnid_t                    out_txnid_0;
    cmd_txnid_t                    out_txnid_1;
    cmd_opcode_t                   out_opcode_0;
    cmd_opcode_t                   out_opcode_1;
    db_entry_id_t                  out_db_id_0;
    db_entry_id_t                  out_db_id_1;
    rob_entry_id_t                 rob_entry_id_0;
    rob_entry_id_t                 rob_entry_id_1;
    logic                          out_grant_rdy;
    logic                          release_vld;
    rob_entry_id_t                 release_idx;

    logic [31:0]                   lfsr;
    logic [ENTRY_NUM-1:0]          free_model;  // Set bit means the entry is free
    logic [IDX_W-1:0]              ptr_model;
    logic [REQ_NUM-1:0]            served;      // Requests taken at the last rising edge
    logic                          first_cycle;
    string                         test_name;

    tb_clk_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    vec_cache_req_frontend vec_cache_req_frontend_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_vld         (req_vld),
        .req_addr        (req_addr),
        .req_txnid       (req_txnid),
        .req_opcode      (req_opcode),
        .req_db_id       (req_db_id),
        .req_rdy         (req_rdy),
        .out_grant_vld_0 (out_grant_vld_0),
        .out_addr_0      (out_addr_0),
        .out_txnid_0     (out_txnid_0),
        .out_opcode_0    (out_opcode_0),
        .out_db_id_0     (out_db_id_0),
        .rob_entry_id_0  (rob_entry_id_0),
        .out_grant_vld_1 (out_grant_vld_1),
        .out_addr_1      (out_addr_1),
        .out_txnid_1     (out_txnid_1),
        .out_opcode_1    (out_opcode_1),
        .out_db_id_1     (out_db_id_1),
        .rob_entry_id_1  (rob_entry_id_1),
        .out_grant_rdy   (out_grant_rdy),
        .release_vld     (release_vld),
        .release_idx     (release_idx)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("FAIL %s %s expected %0h actual %0h", test_name, what,
                               expected, actual));
        end
    endtask

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Round-robin winners from the pointer and the two lowest free entries
    function automatic logic [PRED_W-1:0] predict_grants(input logic [IDX_W-1:0] ptr,
            input logic [REQ_NUM-1:0] vld, input logic [ENTRY_NUM-1:0] free);
        int               hits;
        int               frees;
        int               j;
        logic [IDX_W-1:0] idx0;
        logic [IDX_W-1:0] idx1;
        rob_entry_id_t    rob0;
        rob_entry_id_t    rob1;
        hits  = 0;
        frees = 0;
        idx0  = '0;
        idx1  = '0;
        rob0  = '0;
        rob1  = '0;
        for (int k = 0; k < REQ_NUM; k++) begin
            j = (int'(ptr) + k) % REQ_NUM;
            if (vld[j]) begin
                if (hits == 0) begin
                    idx0 = IDX_W'(j);
                end else if (hits == 1) begin
                    idx1 = IDX_W'(j);
                end
                hits++;
            end
        end
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (free[e]) begin
                if (frees == 0) begin
                    rob0 = rob_entry_id_t'(e);
                end else if (frees == 1) begin
                    rob1 = rob_entry_id_t'(e);
                end
                frees++;
            end
        end
        return {hits >= 1 && frees >= 1, hits >= 2 && frees >= 2, idx0, idx1, rob0, rob1};
    endfunction

    task automatic release_random();
        logic [31:0] r;
        int          e;
        take_bits(ROB_W, r);
        e = int'(r[ROB_W-1:0]);
        while (free_model[e]) begin
            e = (e + 1) % ENTRY_NUM;
        end
        release_vld = 1'b1;
        release_idx = rob_entry_id_t'(e);
    endtask

    task automatic drive_cycle(input bit req_on, input int rdy_mode, input int rel_mode);
        logic [31:0] r;
        @(negedge clk);
        req_vld = req_vld & ~served;
        for (int i = 0; i < REQ_NUM; i++) begin
            take_bits(1, r);
            if (req_on && !req_vld[i] && r[0]) begin
                req_vld[i] = 1'b1;
                take_bits($bits(cmd_addr_t), r);
                req_addr[i] = cmd_addr_t'(r);
                take_bits($bits(cmd_txnid_t), r);
                req_txnid[i] = cmd_txnid_t'(r);
                take_bits($bits(cmd_opcode_t), r);
                req_opcode[i] = cmd_opcode_t'(r);
                take_bits($bits(db_entry_id_t), r);
                req_db_id[i] = db_entry_id_t'(r);
            end
        end
        if (rdy_mode == RDY_RANDOM) begin
            take_bits(2, r);
            out_grant_rdy = (r[1:0] != 2'b00);  // Ready about three cycles in four
        end else begin
            out_grant_rdy = (rdy_mode == RDY_HIGH);
        end
        release_vld = 1'b0;
        if (rel_mode != REL_NONE && free_model != '1) begin
            take_bits(1, r);
            if (rel_mode == REL_ONE || r[0]) begin
                release_random();
            end
        end
    endtask

    always @(posedge clk) begin
        logic [IDX_W-1:0]   e_idx0;
        logic [IDX_W-1:0]   e_idx1;
        rob_entry_id_t      e_rob0;
        rob_entry_id_t      e_rob1;
        logic               e_vld0;
        logic               e_vld1;
        logic [REQ_NUM-1:0] e_rdy;
        if (!rst_n) begin
            check_value("grant valids in reset", '0, 32'({out_grant_vld_1, out_grant_vld_0}));
            check_value("req_rdy in reset", '0, 32'(req_rdy));
            free_model  = '1;
            ptr_model   = '0;
            served      = '0;
            first_cycle = 1'b1;
        end else begin
            {e_vld0, e_vld1, e_idx0, e_idx1, e_rob0, e_rob1} =
                predict_grants(ptr_model, req_vld, free_model);
            if (first_cycle) begin
                check_value("first allocation 0", '0, 32'(rob_entry_id_0));
                check_value("first allocation 1", 32'd1, 32'(rob_entry_id_1));
                first_cycle = 1'b0;
            end
            e_rdy = '0;
            if (e_vld0 && out_grant_rdy) begin
                e_rdy[e_idx0] = 1'b1;
            end
            if (e_vld1 && out_grant_rdy) begin
                e_rdy[e_idx1] = 1'b1;
            end
            check_value("grant valids", 32'({e_vld1, e_vld0}),
                        32'({out_grant_vld_1, out_grant_vld_0}));
            check_value("req_rdy", 32'(e_rdy), 32'(req_rdy));
            if (e_vld0) begin
                check_value("slot 0 addr", req_addr[e_idx0], out_addr_0);
                check_value("slot 0 txnid", 32'(req_txnid[e_idx0]), 32'(out_txnid_0));
                check_value("slot 0 opcode", 32'(req_opcode[e_idx0]), 32'(out_opcode_0));
                check_value("slot 0 db id", 32'(req_db_id[e_idx0]), 32'(out_db_id_0));
                check_value("slot 0 rob id", 32'(e_rob0), 32'(rob_entry_id_0));
            end
            if (e_vld1) begin
                check_value("slot 1 addr", req_addr[e_idx1], out_addr_1);
                check_value("slot 1 txnid", 32'(req_txnid[e_idx1]), 32'(out_txnid_1));
                check_value("slot 1 opcode", 32'(req_opcode[e_idx1]), 32'(out_opcode_1));
                check_value("slot 1 db id", 32'(req_db_id[e_idx1]), 32'(out_db_id_1));
                check_value("slot 1 rob id", 32'(e_rob1), 32'(rob_entry_id_1));
            end
            if (e_vld0 && out_grant_rdy) begin
                free_model[e_rob0] = 1'b0;
                ptr_model = (e_idx0 == IDX_W'(REQ_NUM - 1)) ? '0 : e_idx0 + 1'b1;
            end
            if (e_vld1 && out_grant_rdy) begin
                free_model[e_rob1] = 1'b0;
            end
            if (release_vld) begin
                free_model[release_idx] = 1'b1;  // Free again from the next cycle
            end
            served = e_rdy;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("Timeout after %0d cycles during %s", WATCHDOG_CYCLES, test_name));
    end

    initial begin
        req_vld       = '0;
        req_addr      = '0;
        req_txnid     = '0;
        req_opcode    = '0;
        req_db_id     = '0;
        out_grant_rdy = 1'b0;
        release_vld   = 1'b0;
        release_idx   = '0;
        lfsr          = 32'h7df8;
        test_name     = "reset";
        @(posedge rst_n);
        test_name = "round_robin";
        repeat (RANDOM_CYCLES) drive_cycle(1'b1, RDY_RANDOM, REL_RANDOM);
        test_name = "back_pressure";
        repeat (STALL_CYCLES) drive_cycle(1'b1, RDY_LOW, REL_NONE);
        test_name = "exhaustion";
        while (free_model != '0) begin
            drive_cycle(1'b1, RDY_HIGH, REL_NONE);
        end
        repeat (EMPTY_CYCLES) drive_cycle(1'b1, RDY_HIGH, REL_NONE);
        // One entry comes back at a time and is reissued in the next cycle
        test_name = "release";
        repeat (ENTRY_NUM) begin
            drive_cycle(1'b1, RDY_HIGH, REL_ONE);
            drive_cycle(1'b1, RDY_HIGH, REL_NONE);
        end
        test_name = "drain";
        while (req_vld != '0 || free_model != '1) begin
            drive_cycle(1'b0, RDY_HIGH, REL_RANDOM);
        end
        drive_cycle(1'b0, RDY_HIGH, REL_NONE);
        // With every entry back the free list offers entries 0 and 1 again
        check_value("final allocation 0", '0, 32'(rob_entry_id_0));
        check_value("final allocation 1", 32'd1, 32'(rob_entry_id_1));
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vec_cache_req.f
+incdir+rtl
rtl/vector_cache_pkg.sv
rtl/n_to_2_arb.sv
rtl/mshr_free_list.sv
rtl/vec_cache_8to2_req_arbiter.sv
rtl/vec_cache_req_frontend.sv
verif/tb_clk_gen.sv
verif/tb_vec_cache_req_frontend.sv

//--- Makefile
TOP := tb_vec_cache_req_frontend

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f vec_cache_req.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
